//--- periph_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, types and memory-map constants for the PC/XT memory
// block. Every RTL module of the block imports this package by wildcard.
////////////////////////////////////////////////////////////////////////////
package periph_pkg;

    // CPU bus widths
    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;

    // One bank holds 32 KB
    localparam int BANK_AW   = 15;
    localparam int NUM_BANKS = 4;

    // Upper address bits that select a 32 KB window
    localparam int WIN_W     = ADDR_W - BANK_AW;

    // Load port address width, only the low BANK_AW bits reach the ROM
    localparam int LOAD_AW   = 16;

    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [DATA_W-1:0]              data_t;
    typedef logic [BANK_AW-1:0]             bank_addr_t;
    typedef logic [$clog2(NUM_BANKS)-1:0]   bank_idx_t;

    // Bank numbering
    localparam bank_idx_t BANK_RAM = 2'd0;
    localparam bank_idx_t BANK_MDA = 2'd1;
    localparam bank_idx_t BANK_CGA = 2'd2;
    localparam bank_idx_t BANK_ROM = 2'd3;

    // Window base, top five address bits, indexed by bank number
    //   RAM 00000-07FFF
    //   MDA B0000-B7FFF
    //   CGA B8000-BFFFF
    //   ROM F8000-FFFFF
    localparam logic [WIN_W-1:0] bank_base [NUM_BANKS] = '{
        5'b00000,
        5'b10110,
        5'b10111,
        5'b11111
    };

endpackage

//--- mem_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Memory-map decoder. Turns CPU strobes, the CPU address and the ROM load
// port into one-hot bank enables, a shared write enable, bank address and
// write data, plus the read hit that feeds the read-return stage.
////////////////////////////////////////////////////////////////////////////
module mem_decoder
    import periph_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    // CPU bus, strobes active low
    input  logic                    address_enable_n_i,
    input  logic                    memory_read_n_i,
    input  logic                    memory_write_n_i,
    input  addr_t                   address_i,
    input  data_t                   data_bus_i,
    // Video window enables
    input  logic                    enable_mda_i,
    input  logic                    enable_cga_i,
    // ROM load port
    input  logic                    ioctl_download_i,
    input  logic                    ioctl_wr_i,
    input  logic [LOAD_AW-1:0]      ioctl_addr_i,
    input  data_t                   ioctl_data_i,
    // To the banks
    output logic [NUM_BANKS-1:0]    bank_en_o,
    output logic                    bank_we_o,
    output bank_addr_t              bank_addr_o,
    output data_t                   bank_wdata_o,
    // To read-return
    output logic                    rd_hit_o,
    output bank_idx_t               rd_bank_o
);

    logic [NUM_BANKS-1:0]   window_on;
    logic [NUM_BANKS-1:0]   hit;
    logic                   any_hit;
    bank_idx_t              hit_idx;
    logic                   prev_write_n;
    logic                   write_edge;
    logic                   cpu_we;
    logic                   cpu_en;
    logic                   load_we;

    // Which windows answer right now
    always_comb begin
        window_on           = '1;
        window_on[BANK_RAM] = 1'b1;
        window_on[BANK_MDA] = enable_mda_i;
        window_on[BANK_CGA] = enable_cga_i;
        // CPU loses the ROM while a download runs
        window_on[BANK_ROM] = ~ioctl_download_i;
    end

    // Windows are disjoint, so at most one bit is set
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            hit[i] = ~address_enable_n_i & window_on[i]
                   & (address_i[ADDR_W-1:BANK_AW] == bank_base[i]);
        end
    end

    assign any_hit = |hit;

    // Bank number of the hit window
    always_comb begin
        hit_idx = BANK_RAM;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (hit[i]) begin
                hit_idx = bank_idx_t'(i);
            end
        end
    end

    // Previous write strobe, starts out idle
    always_ff @(posedge clock) begin
        if (reset) begin
            prev_write_n <= 1'b1;
        end else begin
            prev_write_n <= memory_write_n_i;
        end
    end

    // One write per strobe, taken on its first low cycle
    assign write_edge = ~memory_write_n_i & prev_write_n;

    // ROM is read-only from the CPU side
    assign cpu_we  = write_edge & any_hit & ~hit[BANK_ROM];
    assign cpu_en  = cpu_we | ~memory_read_n_i;
    assign load_we = ioctl_download_i & ioctl_wr_i;

    // Load port owns the shared bank bus when it writes
    always_comb begin
        if (load_we) begin
            bank_en_o           = '0;
            bank_en_o[BANK_ROM] = 1'b1;
            bank_we_o           = 1'b1;
            bank_addr_o         = ioctl_addr_i[BANK_AW-1:0];
            bank_wdata_o        = ioctl_data_i;
        end else begin
            bank_en_o           = cpu_en ? hit : '0;
            bank_we_o           = cpu_we;
            bank_addr_o         = address_i[BANK_AW-1:0];
            bank_wdata_o        = data_bus_i;
        end
    end

    // No read result when the bank is busy writing this cycle
    assign rd_hit_o  = ~memory_read_n_i & any_hit & ~bank_we_o;
    assign rd_bank_o = hit_idx;

endmodule

//--- mem_bank.sv
////////////////////////////////////////////////////////////////////////////
// Single-port synchronous byte memory, one cycle of read latency.
// The read register holds its value while the bank is not enabled.
////////////////////////////////////////////////////////////////////////////
module mem_bank
    import periph_pkg::*;
#(
    parameter int ADDR_W = BANK_AW
) (
    input  logic                clock,
    input  logic                en_i,
    input  logic                we_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  data_t               wdata_i,
    output data_t               rdata_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    // Inferred block RAM
    data_t mem [DEPTH];

    // Write or read, never both in one cycle
    always_ff @(posedge clock) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

//--- read_return.sv
////////////////////////////////////////////////////////////////////////////
// Read-return stage. Delays the read hit and bank number by the bank
// latency, then drives the CPU data-out bus and its valid flag.
////////////////////////////////////////////////////////////////////////////
module read_return
    import periph_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    // From the decoder, same cycle as the bank enable
    input  logic                    rd_hit_i,
    input  bank_idx_t               rd_bank_i,
    // Registered bank outputs
    input  data_t [NUM_BANKS-1:0]   bank_rdata_i,
    // CPU side
    output data_t                   data_bus_o,
    output logic                    data_from_chipset_o
);

    logic       hit_q;
    bank_idx_t  bank_q;

    // Valid flag starts low
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= rd_hit_i;
        end
    end

    // Bank number only matters while hit_q is high
    always_ff @(posedge clock) begin
        bank_q <= rd_bank_i;
    end

    // Same cycle as the bank data, no extra stage
    always_comb begin
        if (hit_q) begin
            data_from_chipset_o = 1'b1;
            data_bus_o          = bank_rdata_i[bank_q];
        end else begin
            data_from_chipset_o = 1'b0;
            data_bus_o          = '0;
        end
    end

endmodule

//--- periph_mem_bus.sv
////////////////////////////////////////////////////////////////////////////
// Memory side of the PC/XT peripheral block. Decoder, four identical
// 32 KB banks (low RAM, MDA and CGA text buffers, BIOS ROM) and the
// read-return stage onto the CPU data bus.
////////////////////////////////////////////////////////////////////////////
module periph_mem_bus
    import periph_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    // CPU bus
    input  logic                address_enable_n_i,
    input  logic                memory_read_n_i,
    input  logic                memory_write_n_i,
    input  addr_t               address_i,
    input  data_t               data_bus_i,
    // Video window enables
    input  logic                enable_mda_i,
    input  logic                enable_cga_i,
    // ROM load port
    input  logic                ioctl_download_i,
    input  logic                ioctl_wr_i,
    input  logic [LOAD_AW-1:0]  ioctl_addr_i,
    input  data_t               ioctl_data_i,
    // Read data back to the CPU
    output data_t               data_bus_o,
    output logic                data_from_chipset_o
);

    logic [NUM_BANKS-1:0]   bank_en;
    logic                   bank_we;
    bank_addr_t             bank_addr;
    data_t                  bank_wdata;
    logic                   rd_hit;
    bank_idx_t              rd_bank;
    data_t [NUM_BANKS-1:0]  bank_rdata;

    mem_decoder u_mem_decoder (
        .clock              (clock),
        .reset              (reset),
        .address_enable_n_i (address_enable_n_i),
        .memory_read_n_i    (memory_read_n_i),
        .memory_write_n_i   (memory_write_n_i),
        .address_i          (address_i),
        .data_bus_i         (data_bus_i),
        .enable_mda_i       (enable_mda_i),
        .enable_cga_i       (enable_cga_i),
        .ioctl_download_i   (ioctl_download_i),
        .ioctl_wr_i         (ioctl_wr_i),
        .ioctl_addr_i       (ioctl_addr_i),
        .ioctl_data_i       (ioctl_data_i),
        .bank_en_o          (bank_en),
        .bank_we_o          (bank_we),
        .bank_addr_o        (bank_addr),
        .bank_wdata_o       (bank_wdata),
        .rd_hit_o           (rd_hit),
        .rd_bank_o          (rd_bank)
    );

    // Shared write enable, qualified per bank by its enable bit
    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        mem_bank #(
            .ADDR_W (BANK_AW)
        ) u_mem_bank (
            .clock   (clock),
            .en_i    (bank_en[i]),
            .we_i    (bank_we),
            .addr_i  (bank_addr),
            .wdata_i (bank_wdata),
            .rdata_o (bank_rdata[i])
        );
    end

    read_return u_read_return (
        .clock               (clock),
        .reset               (reset),
        .rd_hit_i            (rd_hit),
        .rd_bank_i           (rd_bank),
        .bank_rdata_i        (bank_rdata),
        .data_bus_o          (data_bus_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule

//--- tb_periph_mem_bus.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the PC/XT memory block. Random CPU and load-port traffic
// is checked against a shadow memory by a reference model of the map.
// Every read is checked one clock after its edge.
////////////////////////////////////////////////////////////////////////////
module tb_periph_mem_bus
    import periph_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_TIMEOUT = 20;
    localparam int IDLE_TIMEOUT  = 8;

    logic                clock = 1'b0;
    logic                reset;
    logic                address_enable_n;
    logic                memory_read_n;
    logic                memory_write_n;
    addr_t               address;
    data_t               data_bus;
    logic                enable_mda;
    logic                enable_cga;
    logic                ioctl_download;
    logic                ioctl_wr;
    logic [LOAD_AW-1:0]  ioctl_addr;
    data_t               ioctl_data;
    data_t               data_bus_out;
    logic                data_from_chipset;

    // Expected memory contents with one row per bank
    data_t       shadow [NUM_BANKS][2**BANK_AW];
    logic [31:0] lfsr_state;

    logic        chk_pending;
    logic [8:0]  exp_resp;
    addr_t       exp_addr;
    int          checks_done;

    periph_mem_bus u_periph_mem_bus (
        .clock               (clock),
        .reset               (reset),
        .address_enable_n_i  (address_enable_n),
        .memory_read_n_i     (memory_read_n),
        .memory_write_n_i    (memory_write_n),
        .address_i           (address),
        .data_bus_i          (data_bus),
        .enable_mda_i        (enable_mda),
        .enable_cga_i        (enable_cga),
        .ioctl_download_i    (ioctl_download),
        .ioctl_wr_i          (ioctl_wr),
        .ioctl_addr_i        (ioctl_addr),
        .ioctl_data_i        (ioctl_data),
        .data_bus_o          (data_bus_out),
        .data_from_chipset_o (data_from_chipset)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic data_t rand_byte();
        logic [31:0] r;
        r = rand_bits(8);
        return r[7:0];
    endfunction

    function automatic addr_t rand_in_window(input logic [4:0] top);
        logic [31:0] r;
        r = rand_bits(15);
        return {top, r[14:0]};
    endfunction

    // Bank that answers an address or -1 when none does
    function automatic int window_of(input addr_t a, input logic mda, input logic cga,
                                     input logic dl);
        case (a[19:15])
            5'b00000: return 0;
            5'b10110: return mda ? 1 : -1;
            5'b10111: return cga ? 2 : -1;
            5'b11111: return dl ? -1 : 3;
            default:  return -1;
        endcase
    endfunction

    // Expected {valid, data} for a read seen at a clock edge
    function automatic logic [8:0] ref_read(input addr_t a, input logic aen_n,
                                            input logic mda, input logic cga,
                                            input logic dl);
        int w;
        w = window_of(a, mda, cga, dl);
        if (aen_n || w < 0) begin
            return 9'h000;
        end
        return {1'b1, shadow[w][a[14:0]]};
    endfunction

    // ROM never takes CPU writes
    function automatic logic write_taken(input addr_t a);
        int w;
        w = window_of(a, enable_mda, enable_cga, ioctl_download);
        return (w >= 0) && (w != 3);
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while %s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Expected response captured at the read edge
    always @(posedge clock) begin
        if (reset) begin
            chk_pending <= 1'b0;
        end else begin
            chk_pending <= ~memory_read_n;
            exp_resp    <= ref_read(address, address_enable_n, enable_mda, enable_cga,
                                    ioctl_download);
            exp_addr    <= address;
        end
    end

    // Responses sampled mid-cycle at the falling edge
    always @(negedge clock) begin
        if (chk_pending) begin
            check_equal({data_from_chipset, data_bus_out}, exp_resp,
                        $sformatf("read response for address %h", exp_addr));
            checks_done++;
        end else if (reset === 1'b0) begin
            // No read at the last edge, so valid low and data zero
            check_equal({data_from_chipset, data_bus_out}, 32'h0,
                        "response outside a read cycle");
        end
    end

    task automatic bus_idle();
        @(negedge clock);
        address_enable_n = 1'b1;
        memory_read_n    = 1'b1;
        memory_write_n   = 1'b1;
        ioctl_wr         = 1'b0;
    endtask

    task automatic set_mode(input logic mda, input logic cga, input logic dl);
        @(negedge clock);
        enable_mda     = mda;
        enable_cga     = cga;
        ioctl_download = dl;
    endtask

    task automatic cpu_write(input addr_t a, input data_t d);
        @(negedge clock);
        address_enable_n = 1'b0;
        memory_write_n   = 1'b0;
        address          = a;
        data_bus         = d;
        if (write_taken(a)) begin
            shadow[window_of(a, enable_mda, enable_cga, ioctl_download)][a[14:0]] = d;
        end
        bus_idle();
    endtask

    // Strobe stays low while the data changes
    task automatic held_write(input addr_t a, input data_t d1, input data_t d2);
        @(negedge clock);
        address_enable_n = 1'b0;
        memory_write_n   = 1'b0;
        address          = a;
        data_bus         = d1;
        if (write_taken(a)) begin
            shadow[window_of(a, enable_mda, enable_cga, ioctl_download)][a[14:0]] = d1;
        end
        @(negedge clock);
        data_bus = d2;
        @(negedge clock);
        bus_idle();
    endtask

    task automatic cpu_read(input addr_t a, input logic aen_n);
        @(negedge clock);
        address_enable_n = aen_n;
        memory_read_n    = 1'b0;
        address          = a;
        bus_idle();
    endtask

    task automatic read_burst(input addr_t addrs[$]);
        @(negedge clock);
        address_enable_n = 1'b0;
        memory_read_n    = 1'b0;
        address          = addrs[0];
        for (int i = 1; i < addrs.size(); i++) begin
            @(negedge clock);
            address = addrs[i];
        end
        bus_idle();
    endtask

    task automatic load_write(input logic [LOAD_AW-1:0] la, input data_t d);
        @(negedge clock);
        ioctl_wr   = 1'b1;
        ioctl_addr = la;
        ioctl_data = d;
        if (ioctl_download) begin
            shadow[3][la[14:0]] = d;
        end
        bus_idle();
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (chk_pending && cnt < IDLE_TIMEOUT) begin
            @(negedge clock);
            cnt++;
        end
        if (chk_pending) begin
            fail_timeout("draining outstanding read checks");
        end
    endtask

    // Reset over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
    end

    initial begin
        addr_t              ram_q[$];
        addr_t              mda_q[$];
        addr_t              cga_q[$];
        addr_t              rom_q[$];
        addr_t              burst_q[$];
        addr_t              a;
        logic [31:0]        r;
        int                 cnt;

        address_enable_n = 1'b1;
        memory_read_n    = 1'b1;
        memory_write_n   = 1'b1;
        address          = '0;
        data_bus         = '0;
        enable_mda       = 1'b0;
        enable_cga       = 1'b0;
        ioctl_download   = 1'b0;
        ioctl_wr         = 1'b0;
        ioctl_addr       = '0;
        ioctl_data       = '0;
        lfsr_state       = 32'h2dd6_100e;
        checks_done      = 0;

        cnt = 0;
        while (reset !== 1'b0 && cnt < RESET_TIMEOUT) begin
            @(negedge clock);
            cnt++;
        end
        if (reset !== 1'b0) begin
            fail_timeout("waiting for reset release");
        end

        // Low RAM write then read
        for (int i = 0; i < 16; i++) begin
            a = rand_in_window(5'b00000);
            cpu_write(a, rand_byte());
            cpu_read(a, 1'b0);
            ram_q.push_back(a);
        end
        wait_idle();

        // Text buffers enabled and then each one disabled
        set_mode(1'b1, 1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            a = rand_in_window(5'b10110);
            cpu_write(a, rand_byte());
            cpu_read(a, 1'b0);
            mda_q.push_back(a);
            a = rand_in_window(5'b10111);
            cpu_write(a, rand_byte());
            cpu_read(a, 1'b0);
            cga_q.push_back(a);
        end
        set_mode(1'b0, 1'b1, 1'b0);
        foreach (mda_q[i]) begin
            cpu_read(mda_q[i], 1'b0);
            cpu_write(mda_q[i], rand_byte());
        end
        set_mode(1'b1, 1'b0, 1'b0);
        foreach (cga_q[i]) begin
            cpu_read(cga_q[i], 1'b0);
            cpu_write(cga_q[i], rand_byte());
        end
        set_mode(1'b1, 1'b1, 1'b0);
        foreach (mda_q[i]) begin
            cpu_read(mda_q[i], 1'b0);
            cpu_read(cga_q[i], 1'b0);
        end
        wait_idle();

        // ROM download with the CPU locked out of the window
        set_mode(1'b1, 1'b1, 1'b1);
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(16);
            load_write(r[15:0], rand_byte());
            rom_q.push_back({5'b11111, r[14:0]});
        end
        foreach (rom_q[i]) begin
            cpu_read(rom_q[i], 1'b0);
            cpu_write(rom_q[i], rand_byte());
        end
        set_mode(1'b1, 1'b1, 1'b0);
        foreach (rom_q[i]) begin
            cpu_read(rom_q[i], 1'b0);
            cpu_write(rom_q[i], rand_byte());
            cpu_read(rom_q[i], 1'b0);
        end
        wait_idle();

        // Unmapped space and cycles not owned by the CPU
        for (int i = 0; i < 16; i++) begin
            // Windows 010xx and 110xx hold no bank
            r = rand_bits(3);
            cpu_read(rand_in_window({r[2], 2'b10, r[1:0]}), 1'b0);
            cpu_read(ram_q[i], 1'b1);
        end
        wait_idle();

        // Back-to-back reads across all banks
        for (int i = 0; i < 4; i++) begin
            burst_q.push_back(ram_q[i]);
            burst_q.push_back(mda_q[i]);
            burst_q.push_back(cga_q[i]);
            burst_q.push_back(rom_q[i]);
        end
        read_burst(burst_q);
        wait_idle();

        // One write per strobe
        for (int i = 0; i < 4; i++) begin
            held_write(ram_q[i], rand_byte(), rand_byte());
            cpu_read(ram_q[i], 1'b0);
            held_write(cga_q[i], rand_byte(), rand_byte());
            cpu_read(cga_q[i], 1'b0);
        end
        wait_idle();

        if (checks_done > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("no read responses were checked");
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

//--- list.f
periph_pkg.sv
mem_decoder.sv
mem_bank.sv
read_return.sv
periph_mem_bus.sv
tb_periph_mem_bus.sv
